//--- flist.f
+incdir+hw
hw/hdr_pkg.sv
hw/hdr_reg_file.sv
hw/hdr_scl_gen.sv
hw/ddr_write_ctrl.sv
hw/hdr_tx.sv
hw/hdr_top.sv
verif/hdr_chk.sv
verif/hdr_tb.sv

//--- Bender.yml
package:
  name: hdr_ddr_write

sources:
  - include_dirs:
      - hw
    files:
      - hw/hdr_pkg.sv
      - hw/hdr_reg_file.sv
      - hw/hdr_scl_gen.sv
      - hw/ddr_write_ctrl.sv
      - hw/hdr_tx.sv
      - hw/hdr_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/hdr_chk.sv
      - verif/hdr_tb.sv

//--- verif/hdr_tb.sv
`timescale 1ns/100ps
`include "hdr_config.svh"

module hdr_tb import hdr_pkg::*; ();

   localparam int N_RANDOM = 20;
   // worst case transfer with twice the bus time
   localparam int XFER_CYCLES = (`HDR_MAX_WORDS + 2) * `HDR_WORD_BITS * 2 * `HDR_SCL_HALF;
   localparam int N_XFERS = 3 + N_RANDOM + 2 + 2;   // directed, random, busy, reset
   localparam int WATCHDOG_CYCLES = N_XFERS * XFER_CYCLES + 20000;

   typedef logic [7:0] byte_arr_t [`HDR_DEPTH];
   typedef bit bit_q_t [$];

   logic    i_sys_clk;
   logic    i_reset;
   cfg_wr_t i_cfg;
   logic    i_hdrengine_en;
   logic    o_hdrengine_done;
   logic    o_scl;
   logic    o_sda;
   logic    o_sda_oe;

   byte_arr_t model_mem;   // what the register file should hold
   bit_q_t    got_bits;
   bit_q_t    exp_bits;
   int        done_cnt;
   logic      scl_prev;
   string     cur_name;
   bit        compare_pending;
   int        test_errors;
   int        tests_run;
   int        tests_failed;

   hdr_top dut0 (
      .i_sys_clk        (i_sys_clk),
      .i_reset          (i_reset),
      .i_cfg            (i_cfg),
      .i_hdrengine_en   (i_hdrengine_en),
      .o_hdrengine_done (o_hdrengine_done),
      .o_scl            (o_scl),
      .o_sda            (o_sda),
      .o_sda_oe         (o_sda_oe)
   );

   initial i_sys_clk = 1'b0;
   always #20 i_sys_clk = ~i_sys_clk;

   // data words on the bus for a length byte
   function automatic int word_count(input logic [7:0] len_byte);
      int n;
      n = (len_byte > `HDR_MAX_WORDS) ? `HDR_MAX_WORDS : int'(len_byte);
      if (n == 0) begin
         n = 1;   // zero length still carries one word
      end
      return n;
   endfunction

   function automatic bit_q_t expected_stream(input byte_arr_t regs);
      bit_q_t    bits;
      bit [15:0] payload;
      bit [4:0]  crc;
      bit        fb;
      bit        odd_x;
      bit        even_x;
      int        n;
      n   = word_count(regs[`HDR_ADDR_LEN]);
      crc = `HDR_CRC_INIT;
      for (int w = 0; w <= n; w++) begin
         if (w == 0) begin
            payload = {1'b0, regs[`HDR_ADDR_CMD][6:0], regs[`HDR_ADDR_TGT][6:0], 1'b0};
            bits.push_back(1'b0);
            bits.push_back(1'b1);
         end else begin
            payload = {regs[`HDR_DATA_BASE + 2*w - 2], regs[`HDR_DATA_BASE + 2*w - 1]};
            bits.push_back(1'b1);
            bits.push_back(1'b0);
         end
         odd_x  = 1'b0;
         even_x = 1'b0;
         for (int b = 15; b >= 0; b--) begin
            bits.push_back(payload[b]);
            if (b % 2 == 1) odd_x ^= payload[b];
            else            even_x ^= payload[b];
            if (w > 0) begin   // crc covers data bytes only
               fb  = crc[4] ^ payload[b];
               crc = {crc[3:0], 1'b0};
               if (fb) crc = crc ^ 5'b00101;
            end
         end
         bits.push_back(odd_x);
         bits.push_back(~even_x);
      end
      // crc word is preamble, token 1100 and crc msb first
      bits.push_back(1'b0);
      bits.push_back(1'b1);
      bits.push_back(1'b1);
      bits.push_back(1'b1);
      bits.push_back(1'b0);
      bits.push_back(1'b0);
      for (int b = 4; b >= 0; b--) bits.push_back(crc[b]);
      return bits;
   endfunction

   function automatic logic [19:0] word_at(input bit_q_t q, input int start);
      logic [19:0] w;
      w = 'x;
      for (int i = 0; i < 20 && start + i < q.size(); i++) w[19 - i] = q[start + i];
      return w;
   endfunction

   task automatic cfg_write(input int addr, input logic [7:0] data, input bit track);
      @(posedge i_sys_clk);
      #2;
      i_cfg.en   = 1'b1;
      i_cfg.addr = addr[`HDR_ADDR_W-1:0];
      i_cfg.data = data;
      if (track) model_mem[addr] = data;
   endtask

   task automatic cfg_release();
      @(posedge i_sys_clk);
      #2;
      i_cfg.en = 1'b0;
   endtask

   task automatic configure(input logic [7:0] cmd, input logic [7:0] tgt,
                            input logic [7:0] len_byte);
      int nbytes;
      nbytes = 2 * word_count(len_byte);
      cfg_write(`HDR_ADDR_CMD, cmd, 1'b1);
      cfg_write(`HDR_ADDR_TGT, tgt, 1'b1);
      cfg_write(`HDR_ADDR_LEN, len_byte, 1'b1);
      for (int i = 0; i < nbytes; i++) cfg_write(`HDR_DATA_BASE + i, 8'($urandom), 1'b1);
      cfg_release();
   endtask

   task automatic start_transfer();
      test_errors = 0;
      done_cnt    = 0;
      got_bits.delete();
      exp_bits = expected_stream(model_mem);
      @(posedge i_sys_clk);
      #2;
      i_hdrengine_en = 1'b1;
      @(posedge i_sys_clk);
      #2;
      i_hdrengine_en = 1'b0;
   endtask

   task automatic finish_transfer(input string name);
      int waited;
      waited = 0;
      while (done_cnt == 0 && waited < XFER_CYCLES) begin
         @(negedge i_sys_clk);
         waited++;
      end
      repeat (8) @(negedge i_sys_clk);   // room for a stray second pulse
      cur_name        = name;
      compare_pending = 1'b1;
      wait (!compare_pending);
   endtask

   task automatic report_test(input string name);
      tests_run++;
      if (test_errors == 0) begin
         $display("test %-14s ok", name);
      end else begin
         tests_failed++;
         $display("test %-14s FAILED, %0d errors", name, test_errors);
      end
   endtask

   task automatic run_transfer(input string name);
      start_transfer();
      finish_transfer(name);
      report_test(name);
   endtask

   // receiver samples one bit per scl toggle
   always @(posedge i_sys_clk) begin
      if (!i_reset) begin
         if (o_scl !== scl_prev && o_sda_oe) got_bits.push_back(o_sda);
         if (o_hdrengine_done) done_cnt++;
      end
      scl_prev = o_scl;
   end

   initial begin : compare_proc
      int first_bad;
      forever begin
         wait (compare_pending);
         assert (done_cnt == 1) else begin
            if (done_cnt == 0) begin
               $display("%s: transfer never gave a done pulse", cur_name);
            end else begin
               $display("Error: %s done pulses expected 1 actual %0d", cur_name, done_cnt);
            end
            test_errors++;
         end
         assert (got_bits.size() == exp_bits.size()) else begin
            $display("Error: %s bit count expected %0d actual %0d",
                     cur_name, exp_bits.size(), got_bits.size());
            test_errors++;
         end
         first_bad = -1;
         for (int i = 0; i < exp_bits.size() && i < got_bits.size(); i++) begin
            if (first_bad < 0 && got_bits[i] != exp_bits[i]) first_bad = i;
         end
         assert (first_bad < 0) else begin
            $display("Error: %s word %0d expected %05h actual %05h", cur_name,
                     first_bad / 20, word_at(exp_bits, first_bad / 20 * 20),
                     word_at(got_bits, first_bad / 20 * 20));
            test_errors++;
         end
         compare_pending = 1'b0;
      end
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge i_sys_clk);
      $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
      $display("sim failed");
      $finish;
   end

   initial begin : stimulus
      void'($urandom(7858));
      i_reset         = 1'b1;
      i_cfg           = '0;
      i_hdrengine_en  = 1'b0;
      scl_prev        = 1'b1;
      compare_pending = 1'b0;
      tests_run       = 0;
      tests_failed    = 0;
      for (int i = 0; i < `HDR_DEPTH; i++) model_mem[i] = 8'h00;
      repeat (10) @(posedge i_sys_clk);
      #2;
      i_reset = 1'b0;

      configure(8'h25, 8'h3a, 8'd1);
      run_transfer("single_word");
      configure(8'($urandom), 8'($urandom), 8'd28);
      run_transfer("max_length");
      configure(8'h11, 8'h52, 8'd0);
      run_transfer("zero_length");

      for (int i = 0; i < N_RANDOM; i++) begin
         configure(8'($urandom), 8'($urandom), 8'($urandom_range(31, 0)));
         run_transfer($sformatf("random_%02d", i));
      end

      // config port locked while busy
      configure(8'h4c, 8'h19, 8'd3);
      start_transfer();
      wait (o_sda_oe == 1'b1);
      for (int i = 0; i < 16; i++) cfg_write(i, 8'hc3 ^ 8'(i), 1'b0);
      cfg_release();
      finish_transfer("busy_writes");
      report_test("busy_writes");
      run_transfer("after_busy");

      // reset in the middle of a transfer
      configure(8'h6e, 8'h2d, 8'd12);
      start_transfer();
      repeat (300) @(posedge i_sys_clk);
      #2;
      i_reset = 1'b1;
      repeat (10) @(posedge i_sys_clk);
      #2;
      assert (o_scl === 1'b1) else begin
         $display("Error: mid_reset o_scl expected 1 actual %b", o_scl);
         test_errors++;
      end
      assert (o_sda_oe === 1'b0) else begin
         $display("Error: mid_reset o_sda_oe expected 0 actual %b", o_sda_oe);
         test_errors++;
      end
      assert (o_hdrengine_done === 1'b0) else begin
         $display("Error: mid_reset o_hdrengine_done expected 0 actual %b",
                  o_hdrengine_done);
         test_errors++;
      end
      i_reset = 1'b0;
      for (int i = 0; i < `HDR_DEPTH; i++) model_mem[i] = 8'h00;
      report_test("mid_reset");
      // bytes 12..15 stay unwritten and must read back as zero
      cfg_write(`HDR_ADDR_CMD, 8'h33, 1'b1);
      cfg_write(`HDR_ADDR_TGT, 8'h47, 1'b1);
      cfg_write(`HDR_ADDR_LEN, 8'd4, 1'b1);
      for (int i = 0; i < 4; i++) cfg_write(`HDR_DATA_BASE + i, 8'($urandom), 1'b1);
      cfg_release();
      run_transfer("after_reset");

      repeat (5) @(posedge i_sys_clk);
      $display("tests: %0d run, %0d passed, %0d failed",
               tests_run, tests_run - tests_failed, tests_failed);
      if (tests_failed == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

//--- verif/hdr_chk.sv
`timescale 1ns/100ps

module hdr_chk (
   input logic i_sys_clk,
   input logic i_reset,
   input logic i_done,
   input logic i_scl,
   input logic i_sda,
   input logic i_sda_oe,
   input logic i_shift
);

   done_pulse_a: assert property (@(posedge i_sys_clk) disable iff (i_reset)
      i_done |=> !i_done)
      else $error("done stayed high for two cycles");

   // bus idle means scl parked high
   scl_parked_a: assert property (@(posedge i_sys_clk) disable iff (i_reset)
      !i_sda_oe |-> i_scl)
      else $error("scl low while sda is not driven");

   // sda moves only on the edge after a shift strobe
   sda_shift_a: assert property (@(posedge i_sys_clk) disable iff (i_reset)
      $changed(i_sda) |-> $past(i_shift))
      else $error("sda changed without a shift strobe");

endmodule

bind hdr_top hdr_chk u_chk (
   .i_sys_clk (i_sys_clk),
   .i_reset   (i_reset),
   .i_done    (o_hdrengine_done),
   .i_scl     (o_scl),
   .i_sda     (o_sda),
   .i_sda_oe  (o_sda_oe),
   .i_shift   (scl_shift)
);

//--- hw/hdr_top.sv
`timescale 1ns/100ps
`include "hdr_config.svh"

module hdr_top import hdr_pkg::*; (
   input  logic    i_sys_clk,
   input  logic    i_reset,
   input  cfg_wr_t i_cfg,
   input  logic    i_hdrengine_en,
   output logic    o_hdrengine_done,
   output logic    o_scl,
   output logic    o_sda,
   output logic    o_sda_oe
);

   ddr_cmd_t               cmd;
   logic [`HDR_ADDR_W-1:0] rd_addr;
   logic [7:0]             rd_data;
   logic                   busy;
   logic                   scl_run;
   logic                   scl_shift;
   logic                   tx_load;
   tx_word_e               tx_kind;
   logic [15:0]            tx_payload;
   logic                   word_done;

   hdr_reg_file u_reg_file (
      .i_sys_clk (i_sys_clk),
      .i_reset   (i_reset),
      .i_cfg     (i_cfg),
      .i_busy    (busy),
      .i_rd_addr (rd_addr),
      .o_rd_data (rd_data),
      .o_cmd     (cmd)
   );

   ddr_write_ctrl u_ddr_write_ctrl (
      .i_sys_clk    (i_sys_clk),
      .i_reset      (i_reset),
      .i_start      (i_hdrengine_en),
      .i_cmd        (cmd),
      .i_rd_data    (rd_data),
      .i_word_done  (word_done),
      .o_rd_addr    (rd_addr),
      .o_busy       (busy),
      .o_scl_run    (scl_run),
      .o_tx_load    (tx_load),
      .o_tx_kind    (tx_kind),
      .o_tx_payload (tx_payload),
      .o_done       (o_hdrengine_done)
   );

   hdr_scl_gen u_scl_gen (
      .i_sys_clk (i_sys_clk),
      .i_reset   (i_reset),
      .i_run     (scl_run),
      .o_scl     (o_scl),
      .o_shift   (scl_shift)
   );

   hdr_tx u_tx (
      .i_sys_clk   (i_sys_clk),
      .i_reset     (i_reset),
      .i_load      (tx_load),
      .i_kind      (tx_kind),
      .i_payload   (tx_payload),
      .i_shift     (scl_shift),
      .o_sda       (o_sda),
      .o_sda_oe    (o_sda_oe),
      .o_word_done (word_done)
   );

endmodule

//--- hw/hdr_tx.sv
`timescale 1ns/100ps
`include "hdr_config.svh"

module hdr_tx import hdr_pkg::*; (
   input  logic        i_sys_clk,
   input  logic        i_reset,
   input  logic        i_load,
   input  tx_word_e    i_kind,
   input  logic [15:0] i_payload,
   input  logic        i_shift,
   output logic        o_sda,
   output logic        o_sda_oe,
   output logic        o_word_done
);

   logic [`HDR_WORD_BITS-1:0] shift_q;
   logic [4:0]                bit_cnt;
   logic [4:0]                last_idx;
   tx_word_e                  kind_q;
   logic [4:0]                crc_q;
   logic                      active;
   logic [1:0]                parity;

   // CRC5, poly x^5+x^2+1, data taken MSB first
   function automatic logic [4:0] crc5_next(input logic [4:0] crc, input logic [15:0] data);
      logic [4:0] c;
      logic       fb;
      c = crc;
      for (int i = 15; i >= 0; i--) begin
         fb = c[4] ^ data[i];
         c  = {c[3:0], 1'b0} ^ (fb ? 5'b00101 : 5'b00000);
      end
      return c;
   endfunction

   // odd bits xor, then even bits xor inverted
   assign parity = {^(i_payload & 16'hAAAA), ~^(i_payload & 16'h5555)};

   assign o_word_done = active && i_shift && (bit_cnt == last_idx);

   always_ff @(posedge i_sys_clk) begin
      if (i_reset) begin
         o_sda    <= 1'b1;
         o_sda_oe <= 1'b0;
         active   <= 1'b0;
         bit_cnt  <= '0;
         last_idx <= '0;
         kind_q   <= WORD_CMD;
         crc_q    <= `HDR_CRC_INIT;
      end else if (i_load) begin
         active   <= 1'b1;
         o_sda_oe <= 1'b1;
         bit_cnt  <= '0;
         kind_q   <= i_kind;
         case (i_kind)
            WORD_CMD: begin
               shift_q  <= {2'b01, i_payload, parity};
               last_idx <= 5'(`HDR_WORD_BITS - 1);
               crc_q    <= `HDR_CRC_INIT;   // new transfer
            end
            WORD_DATA: begin
               shift_q  <= {2'b10, i_payload, parity};
               last_idx <= 5'(`HDR_WORD_BITS - 1);
               crc_q    <= crc5_next(crc_q, i_payload);
            end
            default: begin
               shift_q  <= {2'b01, 4'b1100, crc_q,
                            {(`HDR_WORD_BITS - `HDR_CRC_BITS){1'b0}}};
               // one shift past the last bit releases the bus
               last_idx <= 5'(`HDR_CRC_BITS);
            end
         endcase
      end else if (o_word_done && (kind_q == WORD_CRC)) begin
         active   <= 1'b0;
         o_sda_oe <= 1'b0;
      end else if (active && i_shift) begin
         o_sda   <= shift_q[`HDR_WORD_BITS-1];
         shift_q <= {shift_q[`HDR_WORD_BITS-2:0], 1'b0};
         bit_cnt <= bit_cnt + 1'b1;
      end
   end

endmodule

//--- hw/ddr_write_ctrl.sv
`timescale 1ns/100ps
`include "hdr_config.svh"

module ddr_write_ctrl import hdr_pkg::*; (
   input  logic                   i_sys_clk,
   input  logic                   i_reset,
   input  logic                   i_start,
   input  ddr_cmd_t               i_cmd,
   input  logic [7:0]             i_rd_data,
   input  logic                   i_word_done,
   output logic [`HDR_ADDR_W-1:0] o_rd_addr,
   output logic                   o_busy,
   output logic                   o_scl_run,
   output logic                   o_tx_load,
   output tx_word_e               o_tx_kind,
   output logic [15:0]            o_tx_payload,
   output logic                   o_done
);

   ddr_state_e            state_q;
   logic [`HDR_LEN_W-1:0] words_left;   // data words not yet loaded
   logic [1:0]            fetch_ph;
   logic [15:0]           next_word;    // prefetched data payload

   assign o_busy = (state_q != IDLE);
   assign o_done = (state_q == DONE);

   // SCL stops on the serializer's release shift at the end of the CRC word
   assign o_scl_run = (state_q == CMD) || (state_q == DATA) ||
                      ((state_q == CRC) && !i_word_done);

   always_ff @(posedge i_sys_clk) begin
      if (i_reset) begin
         state_q      <= IDLE;
         words_left   <= '0;
         fetch_ph     <= 2'd0;
         next_word    <= 16'h0000;
         o_rd_addr    <= '0;
         o_tx_load    <= 1'b0;
         o_tx_kind    <= WORD_CMD;
         o_tx_payload <= 16'h0000;
      end else begin
         o_tx_load <= 1'b0;

         // two byte fetch, read address runs one cycle ahead of the data
         case (fetch_ph)
            2'd1: begin
               o_rd_addr <= o_rd_addr + 1'b1;
               fetch_ph  <= 2'd2;
            end
            2'd2: begin
               next_word[15:8] <= i_rd_data;   // byte 2k
               o_rd_addr       <= o_rd_addr + 1'b1;
               fetch_ph        <= 2'd3;
            end
            2'd3: begin
               next_word[7:0] <= i_rd_data;    // byte 2k+1
               fetch_ph       <= 2'd0;
            end
            default: ;
         endcase

         case (state_q)
            IDLE: begin
               if (i_start) begin
                  o_tx_load    <= 1'b1;
                  o_tx_kind    <= WORD_CMD;
                  o_tx_payload <= {1'b0, i_cmd.cmd, i_cmd.tgt, 1'b0};   // write bit first
                  // a zero length still sends one word
                  words_left   <= (i_cmd.len == '0) ? `HDR_LEN_W'(1) : i_cmd.len;
                  o_rd_addr    <= `HDR_ADDR_W'(`HDR_DATA_BASE);
                  fetch_ph     <= 2'd1;
                  state_q      <= CMD;
               end
            end
            CMD, DATA: begin
               if (i_word_done) begin
                  o_tx_load <= 1'b1;
                  if (words_left == '0) begin
                     o_tx_kind    <= WORD_CRC;
                     o_tx_payload <= 16'h0000;   // serializer supplies the CRC
                     state_q      <= CRC;
                  end else begin
                     o_tx_kind    <= WORD_DATA;
                     o_tx_payload <= next_word;
                     words_left   <= words_left - 1'b1;
                     state_q      <= DATA;
                     if (words_left != `HDR_LEN_W'(1)) begin
                        fetch_ph <= 2'd1;   // refill for the next word
                     end
                  end
               end
            end
            CRC: begin
               if (i_word_done) begin
                  state_q <= DONE;
               end
            end
            DONE: state_q <= IDLE;   // single done cycle
            default: state_q <= IDLE;
         endcase
      end
   end

endmodule

//--- hw/hdr_scl_gen.sv
`timescale 1ns/100ps
`include "hdr_config.svh"

module hdr_scl_gen (
   input  logic i_sys_clk,
   input  logic i_reset,
   input  logic i_run,
   output logic o_scl,
   output logic o_shift
);

   localparam int unsigned CNT_W = $clog2(`HDR_SCL_HALF);

   logic [CNT_W-1:0] half_cnt;

   // shift strobe sits mid half period away from the SCL edge
   assign o_shift = (half_cnt == CNT_W'(`HDR_SCL_HALF / 2));

   always_ff @(posedge i_sys_clk) begin
      if (i_reset) begin
         half_cnt <= '0;
         o_scl    <= 1'b1;
      end else if (!i_run) begin
         half_cnt <= '0;
         o_scl    <= 1'b1;   // park high
      end else begin
         if (half_cnt == CNT_W'(`HDR_SCL_HALF - 1)) begin
            half_cnt <= '0;
            o_scl    <= ~o_scl;
         end else begin
            half_cnt <= half_cnt + 1'b1;
         end
      end
   end

endmodule

//--- hw/hdr_reg_file.sv
`timescale 1ns/100ps
`include "hdr_config.svh"

module hdr_reg_file import hdr_pkg::*; (
   input  logic                   i_sys_clk,
   input  logic                   i_reset,
   input  cfg_wr_t                i_cfg,
   input  logic                   i_busy,
   input  logic [`HDR_ADDR_W-1:0] i_rd_addr,
   output logic [7:0]             o_rd_data,
   output ddr_cmd_t               o_cmd
);

   logic [7:0] mem [`HDR_DEPTH];
   logic [7:0] len_byte;

   always_ff @(posedge i_sys_clk) begin
      if (i_reset) begin
         for (int i = 0; i < `HDR_DEPTH; i++) begin
            mem[i] <= 8'h00;
         end
         o_rd_data <= 8'h00;
      end else begin
         // configuration port is locked out during a transfer
         if (i_cfg.en && !i_busy) begin
            mem[i_cfg.addr] <= i_cfg.data;
         end
         o_rd_data <= mem[i_rd_addr];   // one cycle read latency
      end
   end

   assign len_byte = mem[`HDR_ADDR_LEN];

   // descriptor decode
   always_comb begin
      o_cmd.cmd = mem[`HDR_ADDR_CMD][6:0];
      o_cmd.tgt = mem[`HDR_ADDR_TGT][6:0];
      if (len_byte > 8'(`HDR_MAX_WORDS)) begin
         o_cmd.len = `HDR_LEN_W'(`HDR_MAX_WORDS);   // saturate
      end else begin
         o_cmd.len = len_byte[`HDR_LEN_W-1:0];
      end
   end

endmodule

//--- hw/hdr_pkg.sv
`include "hdr_config.svh"

package hdr_pkg;

   // configuration write port
   typedef struct packed {
      logic                   en;
      logic [`HDR_ADDR_W-1:0] addr;
      logic [7:0]             data;
   } cfg_wr_t;

   // write descriptor decoded from the register file
   typedef struct packed {
      logic [6:0]            cmd;
      logic [6:0]            tgt;
      logic [`HDR_LEN_W-1:0] len;
   } ddr_cmd_t;

   // write sequencer states
   typedef enum logic [2:0] {
      IDLE,
      CMD,
      DATA,
      CRC,
      DONE
   } ddr_state_e;

   // kind of word handed to the serializer
   typedef enum logic [1:0] {
      WORD_CMD,
      WORD_DATA,
      WORD_CRC
   } tx_word_e;

endpackage

//--- hw/hdr_config.svh
`ifndef HDR_CONFIG_SVH
`define HDR_CONFIG_SVH

// register file geometry
`define HDR_ADDR_W     6
`define HDR_DEPTH      64

// descriptor byte addresses
`define HDR_ADDR_CMD   0    // 7-bit command code
`define HDR_ADDR_TGT   1    // 7-bit target address
`define HDR_ADDR_LEN   2    // data length in words
`define HDR_DATA_BASE  8    // first data byte

// transfer limits
`define HDR_MAX_WORDS  28
`define HDR_LEN_W      5

// SCL half period in system clocks
`define HDR_SCL_HALF   4

// DDR word format
`define HDR_CRC_INIT   5'b11111
`define HDR_WORD_BITS  20
`define HDR_CRC_BITS   11

`endif
